// File: Makefile
# Verilator build and run for the binary128 scaleb unit

TOP = fpScaleUnit_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

# The log decides the outcome, the simulator status is only recorded
test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f compile.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation reported failure"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
fpPkg.sv
fpDecomp.sv
fpScaleb.sv
fpFlags.sv
fpScaleUnit.sv
fpScaleUnit_assert.sv
fpScaleUnit_tb.sv

// File: fpDecomp.sv
/*
 * Binary128 operand decomposer
 * Splits a quad precision value into sign, exponent and significand
 * and classifies it as zero, infinity or NaN. Purely combinational
 */

`timescale 1ns/10ps

module fpDecomp (
	input fpPkg::fp128 value,
	output fpPkg::fpParts parts
);

	// ------------------------------------------------------------------
	// Field tests
	// ------------------------------------------------------------------

	// Exponent is all ones, so the value is either infinity or NaN
	logic expAllOnes;

	// Exponent is zero, which covers zero and subnormal values
	logic expZero;

	// Significand field is empty
	logic sigZero;

	assign expAllOnes = (value.exp == fpPkg::expMax);
	assign expZero = (value.exp == '0);
	assign sigZero = (value.sig == '0);

	// ------------------------------------------------------------------
	// Field extraction and class
	// ------------------------------------------------------------------

	always_comb begin
		// The fields are copied straight through
		parts.sign = value.sign;
		parts.exp = value.exp;
		parts.sig = value.sig;

		// Zero keeps its sign, so both +0 and -0 match here
		parts.isZero = expZero & sigZero;

		// Infinity has an empty significand under the top exponent
		parts.isInf = expAllOnes & sigZero;

		// Any payload under the top exponent is a NaN
		// Quiet and signaling NaNs are not told apart
		parts.isNan = expAllOnes & ~sigZero;
	end

	// Subnormals are not flagged and count as ordinary finite values.
	// The scaleb datapath treats them the same way, so a subnormal
	// operand only has its exponent field moved by the count

endmodule

// File: fpFlags.sv
/*
 * Sticky exception flag register
 * Collects the overflow and underflow bits of each result over
 * ce-enabled cycles until software clears them with a strobe
 */

`timescale 1ns/10ps

module fpFlags (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic clearFlags,
	input fpPkg::fpExcept exc,
	output fpPkg::fpExcept flags
);

	// ------------------------------------------------------------------
	// Flag update
	// ------------------------------------------------------------------

	// Next value of each flag when the pipeline advances
	fpPkg::fpExcept flagsAcc;

	always_comb begin
		flagsAcc.overflow = flags.overflow | exc.overflow;
		flagsAcc.underflow = flags.underflow | exc.underflow;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (clearFlags) begin
			// The clear wins over an exception arriving at the same edge
			// and works whether or not the pipeline is moving
			flags <= '0;
		end else if (ce) begin
			// Only ce-high cycles carry a new result into the flags
			flags <= flagsAcc;
		end
	end

	// While ce is low the result register holds its old value, so
	// skipping those cycles keeps one event from being collected twice

endmodule

// File: fpPkg.sv
/*
 * Shared definitions for the binary128 scaleb unit
 * Holds the field widths, the vector types and the structs that carry
 * operands, decomposed fields and exception bits between the blocks
 */

package fpPkg;

	// ------------------------------------------------------------------
	// Field widths of the quad precision format
	// ------------------------------------------------------------------

	// Biased exponent field
	localparam int expWidth = 15;

	// Stored significand, the hidden bit is not part of the word
	localparam int sigWidth = 112;

	// Scale count is one bit wider than the exponent so that the
	// zero-extended exponent plus the count fits with a spare top bit
	localparam int scaleWidth = 16;

	// ------------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------------

	// Biased exponent
	typedef logic [expWidth-1:0] fpExp;

	// Significand field without the hidden bit
	typedef logic [sigWidth-1:0] fpSig;

	// Two's complement scale count, the top bit is the sign
	typedef logic [scaleWidth-1:0] fpScale;

	// All ones exponent marks infinity or NaN
	localparam fpExp expMax = '1;

	// ------------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------------

	// A binary128 value laid out as it sits in memory, sign on top
	typedef struct packed {
		logic sign;
		fpExp exp;
		fpSig sig;
	} fp128;

	// Fields of an operand together with its class
	// Only one of the class bits can be set at a time
	typedef struct packed {
		logic sign;
		fpExp exp;
		fpSig sig;
		logic isZero;
		logic isInf;
		logic isNan;
	} fpParts;

	// Exception bits, used per result and for the sticky flags
	typedef struct packed {
		logic overflow;
		logic underflow;
	} fpExcept;

endpackage

// File: fpScaleUnit.sv
/*
 * Binary128 scaleb unit top level
 * Joins the two stage scaleb pipeline with the sticky flag register.
 * Adds no latency of its own
 */

`timescale 1ns/10ps

module fpScaleUnit (
	input logic clk,
	input logic rstN,
	input logic ce,
	input fpPkg::fp128 a,
	input fpPkg::fpScale b,
	input logic clearFlags,
	output fpPkg::fp128 o,
	output fpPkg::fpExcept exc,
	output fpPkg::fpExcept flags
);

	// ------------------------------------------------------------------
	// Scaleb datapath
	// ------------------------------------------------------------------

	// Result and its exception bits appear two ce-cycles after the
	// operand and count were sampled
	fpScaleb scaleb (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.a(a),
		.b(b),
		.o(o),
		.exc(exc)
	);

	// ------------------------------------------------------------------
	// Sticky flags
	// ------------------------------------------------------------------

	// The per-result exception bits feed both the output port and
	// the flag register
	fpFlags flagReg (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.clearFlags(clearFlags),
		.exc(exc),
		.flags(flags)
	);

endmodule

// File: fpScaleUnit_assert.sv
/*
 * Concurrent checks on the binary128 scaleb unit
 * Bound into every instance of the top level
 */

`timescale 1ns/10ps

module scaleUnitChecks (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic clearFlags,
	input fpPkg::fp128 o,
	input fpPkg::fpExcept exc,
	input fpPkg::fpExcept flags
);

	// A result either overflows or underflows, never both
	excExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(exc.overflow && exc.underflow))
		else $error("overflow and underflow bits are set together");

	// Overflow always saturates to a signed infinity
	ovfIsInf: assert property (@(posedge clk) disable iff (!rstN)
		exc.overflow |-> (o.exp == fpPkg::expMax && o.sig == '0))
		else $error("overflow result is not an infinity");

	// A ce-low edge must leave the result register alone
	holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
		!ce |=> $stable(o))
		else $error("result changed while ce was low");

	// The clear strobe empties the flags at the next edge
	clearWorks: assert property (@(posedge clk) disable iff (!rstN)
		clearFlags |=> (flags == '0))
		else $error("flags not cleared after the clear strobe");

endmodule

bind fpScaleUnit scaleUnitChecks checks (
	.clk(clk),
	.rstN(rstN),
	.ce(ce),
	.clearFlags(clearFlags),
	.o(o),
	.exc(exc),
	.flags(flags)
);

// File: fpScaleUnit_tb.sv
/*
 * Testbench for the binary128 scaleb unit
 * Drives weighted random operands and counts, predicts results and
 * sticky flags with a reference model and compares on every cycle
 */

`timescale 1ns/10ps

module fpScaleUnit_tb;

	// ------------------------------------------------------------------
	// Run length and clock
	// ------------------------------------------------------------------

	localparam int clkPeriod = 20;
	localparam int resetCycles = 8;
	localparam int numCycles = 3000;

	// Generous margin on top of the stimulus length
	localparam int timeoutNs = (resetCycles + numCycles + 50) * clkPeriod;

	// One expected result together with its exception bits
	typedef struct packed {
		fpPkg::fp128 val;
		fpPkg::fpExcept exc;
	} expEntry;

	logic clk = 1'b0;
	logic rstN;
	logic ce;
	fpPkg::fp128 a;
	fpPkg::fpScale b;
	logic clearFlags;
	fpPkg::fp128 o;
	fpPkg::fpExcept exc;
	fpPkg::fpExcept flags;

	integer seed = 46783;

	// Scoreboard counters
	int errors = 0;
	int checks = 0;
	int ovfSeen = 0;
	int unfSeen = 0;

	// Remaining cycles of a forced stall
	int stallLeft = 0;
	int cycle;

	// Entry 0 is the result on o now and entry 1 sits in the first stage
	expEntry pipe[$];
	fpPkg::fpExcept flagsModel;

	always #(clkPeriod / 2) clk = ~clk;

	fpScaleUnit dut (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.a(a),
		.b(b),
		.clearFlags(clearFlags),
		.o(o),
		.exc(exc),
		.flags(flags)
	);

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------

	// Scaleb result rule for one operand and count
	function automatic expEntry applyScale(fpPkg::fp128 op, fpPkg::fpScale cnt);
		expEntry e;
		logic [31:0] sum;
		e.val = op;
		e.exc = '0;
		// NaN, infinity and zero leave exactly as they came
		if (op.exp == fpPkg::expMax || (op.exp == '0 && op.sig == '0)) begin
			return e;
		end
		// Only the low 16 bits of the sum matter
		sum = {17'd0, op.exp} + {16'd0, cnt};
		if (sum[15] && cnt[15]) begin
			e.val.exp = '0;
			e.exc.underflow = 1'b1;
		end else if (sum[15]) begin
			e.val.exp = fpPkg::expMax;
			e.val.sig = '0;
			e.exc.overflow = 1'b1;
		end else begin
			e.val.exp = sum[14:0];
		end
		return e;
	endfunction

	// Model state moves only on ce-high edges as in the DUT
	always @(posedge clk) begin
		if (!rstN) begin
			pipe.delete();
			pipe.push_back('0);
			pipe.push_back('0);
			flagsModel = '0;
		end else begin
			// Flags see the exception bits on the output before this edge
			if (clearFlags) begin
				flagsModel = '0;
			end else if (ce) begin
				flagsModel.overflow = flagsModel.overflow | pipe[0].exc.overflow;
				flagsModel.underflow = flagsModel.underflow | pipe[0].exc.underflow;
			end
			if (ce) begin
				void'(pipe.pop_front());
				pipe.push_back(applyScale(a, b));
				if (pipe[1].exc.overflow)
					ovfSeen++;
				if (pipe[1].exc.underflow)
					unfSeen++;
			end
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------

	// Weighted pick of an operand class and a matching count
	task automatic pickOperand(output fpPkg::fp128 op, output fpPkg::fpScale cnt);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] kind;
		logic [31:0] pick;
		int sel;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		kind = $random(seed);
		pick = $random(seed);
		sel = kind % 32'd10;
		op.sign = r3[31];
		op.sig = {r3[15:0], r2, r1, r0};
		case (sel)
			0, 1, 2, 3: begin
				// Mid-range exponent and a small count stay in range
				op.exp = 15'h3FFF + {5'd0, pick[9:0]} - 15'd512;
				cnt = {{10{pick[21]}}, pick[21:16]};
			end
			4, 5: begin
				// Close to the top with counts of either sign
				op.exp = 15'h7FFE - {11'd0, pick[3:0]};
				if (pick[6])
					// A count near the negative limit drops the exponent below zero
					cnt = {1'b1, 11'd0, pick[19:16]};
				else
					cnt = pick[5] ? {9'd0, pick[22:16]} : {1'b0, pick[30:16]};
			end
			6, 7: begin
				// Close to the bottom with counts of either sign
				op.exp = 15'd1 + {11'd0, pick[3:0]};
				if (pick[6])
					// A count near the positive limit pushes the exponent past the top
					cnt = {1'b0, 11'h7FF, pick[19:16]};
				else
					cnt = pick[5] ? (16'hFFFF - {9'd0, pick[22:16]}) : {1'b1, pick[30:16]};
			end
			8: begin
				// Signed zero
				op.exp = '0;
				op.sig = '0;
				cnt = pick[31:16];
			end
			default: begin
				// Infinity or a NaN with a payload that is never empty
				op.exp = fpPkg::expMax;
				op.sig = pick[1] ? '0 : {r3[15:0], r2, r1, r0 | 32'd1};
				cnt = pick[31:16];
			end
		endcase
	endtask

	// New inputs for the next rising edge
	task automatic driveInputs(input int n);
		logic [31:0] r;
		r = $random(seed);
		pickOperand(a, b);
		// Every so often ce stays low for a stretch to test the hold
		if (n % 97 == 50)
			stallLeft = 6;
		if (stallLeft > 0) begin
			ce = 1'b0;
			stallLeft--;
		end else begin
			ce = (r[1:0] != 2'b00);
		end
		clearFlags = (r[7:4] == 4'h0);
	endtask

	// ------------------------------------------------------------------
	// Checking
	// ------------------------------------------------------------------

	task automatic compareValue(input logic [127:0] got, input logic [127:0] want,
			input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic checkOutputs();
		compareValue(o, pipe[0].val, "result o");
		compareValue({126'd0, exc}, {126'd0, pipe[0].exc}, "exception bits");
		compareValue({126'd0, flags}, {126'd0, flagsModel}, "sticky flags");
	endtask

	// ------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------

	initial begin
		rstN = 1'b0;
		ce = 1'b0;
		a = '0;
		b = '0;
		clearFlags = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Compare on the falling edge and then drive the next inputs
		for (cycle = 0; cycle < numCycles; cycle++) begin
			checkOutputs();
			driveInputs(cycle);
			@(negedge clk);
		end
		checkOutputs();

		$display("Done: %0d checks, %0d errors, %0d overflows, %0d underflows",
			checks, errors, ovfSeen, unfSeen);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(timeoutNs);
		$display("Timeout: the run did not finish within %0d ns", timeoutNs);
		$display("Test failed");
		$finish;
	end

endmodule

// File: fpScaleb.sv
/*
 * Two stage binary128 scaleb pipeline
 * Adds a signed count to the biased exponent, saturates to infinity on
 * overflow and clamps the exponent to zero on underflow. Special
 * operands pass through unchanged. Both stages advance on ce only
 */

`timescale 1ns/10ps

module fpScaleb (
	input logic clk,
	input logic rstN,
	input logic ce,
	input fpPkg::fp128 a,
	input fpPkg::fpScale b,
	output fpPkg::fp128 o,
	output fpPkg::fpExcept exc
);

	// ------------------------------------------------------------------
	// Declarations
	// ------------------------------------------------------------------

	// Decomposed operand, straight from the combinational splitter
	fpPkg::fpParts aParts;

	// Operand is zero, infinity or NaN and leaves untouched
	logic passIn;

	// Zero-extended exponent plus the count, modulo 2**16
	fpPkg::fpScale sumIn;

	// Stage 1 registers
	fpPkg::fp128 s1Val;
	logic s1Pass;
	logic s1BNeg;
	fpPkg::fpScale s1Sum;

	// Top bit of the registered sum signals that the range was left
	logic sumTop;

	// Stage 2 next values
	fpPkg::fp128 resNext;
	fpPkg::fpExcept excNext;

	// ------------------------------------------------------------------
	// Stage 1 - decompose and add
	// ------------------------------------------------------------------

	fpDecomp decomp (
		.value(a),
		.parts(aParts)
	);

	assign passIn = aParts.isZero | aParts.isInf | aParts.isNan;

	// The exponent is unsigned, so the cast zero-extends it before the add
	assign sumIn = fpPkg::fpScale'(aParts.exp) + b;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Val <= '0;
			s1Pass <= 1'b0;
			s1BNeg <= 1'b0;
			s1Sum <= '0;
		end else if (ce) begin
			// Fields are rebuilt from the decomposer, so a pass-through
			// result is bit-identical to the operand
			s1Val.sign <= aParts.sign;
			s1Val.exp <= aParts.exp;
			s1Val.sig <= aParts.sig;
			s1Pass <= passIn;
			// Sign of the count tells underflow from overflow later on
			s1BNeg <= b[fpPkg::scaleWidth-1];
			s1Sum <= sumIn;
		end
	end

	// ------------------------------------------------------------------
	// Stage 2 - range check and result select
	// ------------------------------------------------------------------

	assign sumTop = s1Sum[fpPkg::scaleWidth-1];

	always_comb begin
		// Default keeps sign, exponent and significand as they came in
		resNext = s1Val;
		excNext = '0;

		if (!s1Pass) begin
			if (sumTop && s1BNeg) begin
				// Exponent went below zero
				// It is clamped and the significand is kept as is, no
				// denormalizing shift is applied
				resNext.exp = '0;
				excNext.underflow = 1'b1;
			end else if (sumTop) begin
				// Exponent ran past the top, result is a signed infinity
				resNext.exp = fpPkg::expMax;
				resNext.sig = '0;
				excNext.overflow = 1'b1;
			end else begin
				// In range, the low bits of the sum are the new exponent
				resNext.exp = s1Sum[fpPkg::expWidth-1:0];
			end
		end
	end

	// Result register, the exception bits travel with the value
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			o <= '0;
			exc <= '0;
		end else if (ce) begin
			o <= resNext;
			exc <= excNext;
		end
	end

	// A sum that lands exactly on the all ones exponent is not caught
	// as an overflow. Its significand decides whether it reads back as
	// infinity or NaN

endmodule
